/* verilog/spi3w_macros.svh */
`ifndef SPI3W_MACROS_SVH
`define SPI3W_MACROS_SVH

// --------------------------------------------------
// Field widths
// --------------------------------------------------
// Shift word
`define SPI3W_DATA_W 32
// CTRL length field, 0 means a full word
`define SPI3W_LEN_W 6
// Half-period count
`define SPI3W_DIV_W 8
// Chip selects
`define SPI3W_SS_N 4
// Register address
`define SPI3W_ADDR_W 2

// --------------------------------------------------
// Register map and CTRL layout
// --------------------------------------------------
`define SPI3W_ADDR_DATA 2'd0
`define SPI3W_ADDR_CTRL 2'd1
`define SPI3W_ADDR_DIV 2'd2
`define SPI3W_ADDR_SS 2'd3

// Length in the low bits
`define SPI3W_CTRL_LEN_LSB 0
// Go on write, busy on read
`define SPI3W_CTRL_GO_BIT 8
// Set for write direction
`define SPI3W_CTRL_DIR_BIT 14

// DIVIDER value out of reset
`define SPI3W_DIV_RST 8'd3
// Longest transfer in bits
`define SPI3W_LEN_MAX 6'd32

`endif

/* verilog/spi3w_pkg.sv */
`include "spi3w_macros.svh"

package spi3w_pkg;

  // --------------------------------------------------
  // Vector types of the register map
  // --------------------------------------------------

  // DATA word, also the bus data width
  typedef logic [`SPI3W_DATA_W-1:0] spi_word_t;

  // Bit count of a transfer
  // 0 and anything above 32 run a full word
  typedef logic [`SPI3W_LEN_W-1:0] spi_len_t;

  // SCK half-period in clk_sys cycles, minus one
  typedef logic [`SPI3W_DIV_W-1:0] spi_div_t;

  // One bit per chip select, bit 0 drives cs_n[0]
  typedef logic [`SPI3W_SS_N-1:0] spi_ss_t;

  // Word address on the register bus
  typedef logic [`SPI3W_ADDR_W-1:0] reg_addr_t;

  // --------------------------------------------------
  // Transfer sequencer
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    // One cycle, chip select low and first bit out
    ASSERT_CS,
    // SCK running until the last falling edge
    SHIFT,
    // Chip select high, busy still set
    RELEASE
  } seq_state_t;

endpackage

/* verilog/spi3w_if.sv */
`timescale 1ns/1ps

interface spi3w_if;

  // Sequencer controls
  logic run;
  logic load;

  // Timer strobes, one clk_sys cycle each
  logic sck_rise;
  logic sck_fall;
  logic last_bit;

  // Config from CTRL and DIVIDER
  logic dir;
  spi3w_pkg::spi_div_t div;
  // Already clamped to 1..32
  spi3w_pkg::spi_len_t len;

  modport cfg (output div, output len, output dir);

  modport seq (input dir, input last_bit, output run, output load);

  modport timer (
    input run, input div, input len,
    output sck_rise, output sck_fall, output last_bit
  );

  modport shifter (input load, input dir, input len, input sck_rise, input sck_fall);

endinterface

/* verilog/spi3w_reg_bank.sv */
`timescale 1ns/1ps
`include "spi3w_macros.svh"

module spi3w_reg_bank (
  input  logic                  clk_sys,
  input  logic                  rst_n_i,
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  spi3w_pkg::reg_addr_t  bus_addr_i,
  input  spi3w_pkg::spi_word_t  bus_wdata_i,
  output logic                  bus_ack_o,
  output spi3w_pkg::spi_word_t  bus_rdata_o,
  input  logic                  busy_i,
  input  spi3w_pkg::spi_word_t  data_i,
  output logic                  data_wr_o,
  output logic                  go_o,
  output spi3w_pkg::spi_ss_t    ss_o,
  spi3w_if.cfg                  cfg
);

  logic                 ack_q;
  spi3w_pkg::spi_word_t rdata_q;
  spi3w_pkg::spi_word_t rd_mux;
  logic                 go_q;
  logic                 busy_any;
  logic                 wr;
  logic                 wr_data;
  logic                 wr_ctrl;
  spi3w_pkg::spi_len_t  len_q;
  logic                 dir_q;
  spi3w_pkg::spi_div_t  div_q;
  spi3w_pkg::spi_ss_t   ss_q;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  assign wr      = bus_req_i && bus_we_i;
  assign wr_data = wr && (bus_addr_i == `SPI3W_ADDR_DATA);
  assign wr_ctrl = wr && (bus_addr_i == `SPI3W_ADDR_CTRL);

  // Go pulse counts as busy before the FSM leaves IDLE
  assign busy_any = busy_i || go_q;

  // DATA lives in the shifter, frozen while shifting
  assign data_wr_o = wr_data && !busy_any;

  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
    begin
      len_q <= '0;
      dir_q <= 1'b0;
      div_q <= `SPI3W_DIV_RST;
      ss_q  <= '0;
      go_q  <= 1'b0;
    end
    else
    begin
      // Length, direction and divider hold still during a transfer
      if (wr_ctrl && !busy_any)
      begin
        len_q <= bus_wdata_i[`SPI3W_CTRL_LEN_LSB +: `SPI3W_LEN_W];
        dir_q <= bus_wdata_i[`SPI3W_CTRL_DIR_BIT];
      end
      if (wr && (bus_addr_i == `SPI3W_ADDR_DIV) && !busy_any)
        div_q <= bus_wdata_i[`SPI3W_DIV_W-1:0];
      // SS is latched by the FSM at start, free to change
      if (wr && (bus_addr_i == `SPI3W_ADDR_SS))
        ss_q <= bus_wdata_i[`SPI3W_SS_N-1:0];
      // Single-cycle go, lines up with the acknowledge
      go_q <= wr_ctrl && bus_wdata_i[`SPI3W_CTRL_GO_BIT] && !busy_any;
    end
  end

  // --------------------------------------------------
  // Read mux and acknowledge
  // --------------------------------------------------
  always_comb
  begin
    rd_mux = '0;
    case (bus_addr_i)
      `SPI3W_ADDR_DATA: rd_mux = data_i;
      `SPI3W_ADDR_CTRL:
      begin
        rd_mux[`SPI3W_CTRL_LEN_LSB +: `SPI3W_LEN_W] = len_q;
        // Go bit reads back as busy
        rd_mux[`SPI3W_CTRL_GO_BIT]  = busy_any;
        rd_mux[`SPI3W_CTRL_DIR_BIT] = dir_q;
      end
      `SPI3W_ADDR_DIV: rd_mux[`SPI3W_DIV_W-1:0] = div_q;
      `SPI3W_ADDR_SS:  rd_mux[`SPI3W_SS_N-1:0] = ss_q;
    endcase
  end

  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_i;
  end

  // Read data valid together with ack
  always_ff @(posedge clk_sys)
  begin
    if (bus_req_i && !bus_we_i)
      rdata_q <= rd_mux;
  end

  assign bus_ack_o   = ack_q;
  assign bus_rdata_o = rdata_q;
  assign go_o        = go_q;
  assign ss_o        = ss_q;

  // Config out, zero length means a full word
  assign cfg.len = ((len_q == '0) || (len_q > `SPI3W_LEN_MAX)) ? `SPI3W_LEN_MAX : len_q;
  assign cfg.dir = dir_q;
  assign cfg.div = div_q;

endmodule

/* verilog/spi3w_seq_fsm.sv */
`timescale 1ns/1ps

module spi3w_seq_fsm (
  input  logic               clk_sys,
  input  logic               rst_n_i,
  input  logic               go_i,
  input  spi3w_pkg::spi_ss_t ss_i,
  output logic               busy_o,
  output spi3w_pkg::spi_ss_t spi_cs_n_o,
  output logic               spi_sdio_oe_o,
  spi3w_if.seq               ctl
);

  spi3w_pkg::seq_state_t state_q;
  spi3w_pkg::seq_state_t state_d;
  spi3w_pkg::spi_ss_t    cs_n_q;
  logic                  oe_q;
  logic                  start;
  logic                  done;

  // Go only taken from IDLE
  assign start = (state_q == spi3w_pkg::IDLE) && go_i;
  // Last falling SCK edge
  assign done  = (state_q == spi3w_pkg::SHIFT) && ctl.last_bit;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      spi3w_pkg::IDLE:
        if (go_i)
          state_d = spi3w_pkg::ASSERT_CS;
      spi3w_pkg::ASSERT_CS:
        state_d = spi3w_pkg::SHIFT;
      spi3w_pkg::SHIFT:
        if (ctl.last_bit)
          state_d = spi3w_pkg::RELEASE;
      spi3w_pkg::RELEASE:
        state_d = spi3w_pkg::IDLE;
    endcase
  end

  // State plus registered pin controls
  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
    begin
      state_q <= spi3w_pkg::IDLE;
      cs_n_q  <= '1;
      oe_q    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (start)
      begin
        // Masked selects low, driver on for writes only
        cs_n_q <= ~ss_i;
        oe_q   <= ctl.dir;
      end
      else if (done)
      begin
        // Same edge as the final SCK fall
        cs_n_q <= '1;
        oe_q   <= 1'b0;
      end
    end
  end

  // Shifter picks its first bit on the cycle CS falls
  assign ctl.load = start;
  // Timer runs from the first CS-low cycle
  assign ctl.run  = (state_q == spi3w_pkg::ASSERT_CS) || (state_q == spi3w_pkg::SHIFT);

  // RELEASE keeps busy one cycle past CS rise
  assign busy_o        = (state_q != spi3w_pkg::IDLE);
  assign spi_cs_n_o    = cs_n_q;
  assign spi_sdio_oe_o = oe_q;

endmodule

/* verilog/spi3w_bit_timer.sv */
`timescale 1ns/1ps

module spi3w_bit_timer (
  input  logic clk_sys,
  input  logic rst_n_i,
  output logic spi_sck_o,
  spi3w_if.timer tmr
);

  spi3w_pkg::spi_div_t cnt_q;
  spi3w_pkg::spi_len_t bits_q;
  logic                sck_q;
  logic                tick;

  // End of a half-period
  assign tick = tmr.run && (cnt_q == tmr.div);

  // Strobes on the cycle before SCK changes
  assign tmr.sck_rise = tick && !sck_q;
  assign tmr.sck_fall = tick && sck_q;
  // bits_q has already counted the final rise
  assign tmr.last_bit = tmr.sck_fall && (bits_q == tmr.len);

  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
    begin
      cnt_q  <= '0;
      bits_q <= '0;
      sck_q  <= 1'b0;
    end
    else if (!tmr.run)
    begin
      // Idle, SCK parked low
      cnt_q  <= '0;
      bits_q <= '0;
      sck_q  <= 1'b0;
    end
    else if (tick)
    begin
      cnt_q <= '0;
      sck_q <= !sck_q;
      // Count rising edges
      if (!sck_q)
        bits_q <= bits_q + 1'b1;
    end
    else
      cnt_q <= cnt_q + 1'b1;
  end

  assign spi_sck_o = sck_q;

endmodule

/* verilog/spi3w_shift_reg.sv */
`timescale 1ns/1ps
`include "spi3w_macros.svh"

module spi3w_shift_reg (
  input  logic                 clk_sys,
  input  logic                 rst_n_i,
  input  logic                 data_wr_i,
  input  spi3w_pkg::spi_word_t wdata_i,
  input  logic                 spi_sdio_i,
  output spi3w_pkg::spi_word_t data_o,
  output logic                 spi_sdio_o,
  spi3w_if.shifter             sh
);

  spi3w_pkg::spi_word_t data_q;
  logic                 sdo_q;
  logic [4:0]           tap_idx;
  logic                 tap_bit;
  logic                 shift_in;

  // --------------------------------------------------
  // Output tap
  // --------------------------------------------------
  // Word is not rotated on load; bit len-1 always holds the
  // next bit out, since each shift moves the next one up to it
  assign tap_idx = 5'(sh.len - 1'b1);
  assign tap_bit = data_q[tap_idx];

  // Read direction samples the pin, write shifts in zeros
  assign shift_in = sh.dir ? 1'b0 : spi_sdio_i;

  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
    begin
      data_q <= '0;
      sdo_q  <= 1'b0;
    end
    else
    begin
      // Bus write, blocked upstream while busy
      if (data_wr_i)
        data_q <= wdata_i;
      else if (sh.sck_rise)
        data_q <= {data_q[`SPI3W_DATA_W-2:0], shift_in};
      // First bit with CS, then a new bit on each SCK fall
      if (sh.load || sh.sck_fall)
        sdo_q <= tap_bit;
    end
  end

  assign data_o     = data_q;
  assign spi_sdio_o = sdo_q;

endmodule

/* verilog/spi3w_top.sv */
`timescale 1ns/1ps

module spi3w_top (
  input  logic                 clk_sys,
  input  logic                 rst_n_i,

  // Register bus, fixed one-cycle ack
  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  spi3w_pkg::reg_addr_t bus_addr_i,
  input  spi3w_pkg::spi_word_t bus_wdata_i,
  output logic                 bus_ack_o,
  output spi3w_pkg::spi_word_t bus_rdata_o,

  // Three-wire SPI, data pin split for simulation
  output logic                 spi_sck_o,
  output spi3w_pkg::spi_ss_t   spi_cs_n_o,
  output logic                 spi_sdio_o,
  output logic                 spi_sdio_oe_o,
  input  logic                 spi_sdio_i
);

  logic                 data_wr;
  logic                 go_pulse;
  logic                 busy;
  spi3w_pkg::spi_ss_t   ss_mask;
  spi3w_pkg::spi_word_t data_rd;

  // Sequencer, timer and shifter handshakes
  spi3w_if spi_if ();

  // --------------------------------------------------
  // Register bank
  // --------------------------------------------------
  spi3w_reg_bank u_reg_bank (
    .clk_sys     (clk_sys),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_ack_o   (bus_ack_o),
    .bus_rdata_o (bus_rdata_o),
    .busy_i      (busy),
    .data_i      (data_rd),
    .data_wr_o   (data_wr),
    .go_o        (go_pulse),
    .ss_o        (ss_mask),
    .cfg         (spi_if.cfg)
  );

  // --------------------------------------------------
  // Transfer engine
  // --------------------------------------------------
  spi3w_seq_fsm u_seq_fsm (
    .clk_sys       (clk_sys),
    .rst_n_i       (rst_n_i),
    .go_i          (go_pulse),
    .ss_i          (ss_mask),
    .busy_o        (busy),
    .spi_cs_n_o    (spi_cs_n_o),
    .spi_sdio_oe_o (spi_sdio_oe_o),
    .ctl           (spi_if.seq)
  );

  spi3w_bit_timer u_bit_timer (
    .clk_sys   (clk_sys),
    .rst_n_i   (rst_n_i),
    .spi_sck_o (spi_sck_o),
    .tmr       (spi_if.timer)
  );

  spi3w_shift_reg u_shift_reg (
    .clk_sys    (clk_sys),
    .rst_n_i    (rst_n_i),
    .data_wr_i  (data_wr),
    .wdata_i    (bus_wdata_i),
    .spi_sdio_i (spi_sdio_i),
    .data_o     (data_rd),
    .spi_sdio_o (spi_sdio_o),
    .sh         (spi_if.shifter)
  );

endmodule

/* tb/spi3w_chk.sv */
`timescale 1ns/1ps

module spi3w_chk (
  input logic                clk_sys,
  input logic                rst_n_i,
  input logic                bus_req_i,
  input logic                bus_ack_i,
  input logic                spi_sck_i,
  input spi3w_pkg::spi_ss_t  spi_cs_n_i,
  input logic                spi_sdio_oe_i,
  input logic                dir_i,
  input spi3w_pkg::spi_div_t div_i
);

  // Failed assertions so far, polled by the testbench
  int unsigned err_cnt = 0;

  logic       cs_on;
  logic       cs_on_q;
  logic       sck_q;
  logic [8:0] lvl_q;

  // Any chip select low
  assign cs_on = !(&spi_cs_n_i);

  // --------------------------------------------------
  // SCK level length while a chip select is low
  // --------------------------------------------------
  always_ff @(posedge clk_sys)
  begin
    if (!rst_n_i)
    begin
      cs_on_q <= 1'b0;
      sck_q   <= 1'b0;
      lvl_q   <= '0;
    end
    else
    begin
      cs_on_q <= cs_on;
      sck_q   <= spi_sck_i;
      // Count restarts on each SCK edge, zero outside a transfer
      if (!cs_on)
        lvl_q <= '0;
      else if (spi_sck_i != sck_q)
        lvl_q <= 9'd1;
      else
        lvl_q <= lvl_q + 9'd1;
    end
  end

  // --------------------------------------------------
  // Bus and pin rules
  // --------------------------------------------------
  ack_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    bus_ack_i == $past(bus_req_i))
  else
  begin
    $error("bus ack does not follow the request by one cycle");
    err_cnt++;
  end

  // Level that just ended began and ran under chip select
  sck_half_period: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    (cs_on_q && (spi_sck_i != sck_q)) |-> (lvl_q == ({1'b0, div_i} + 9'd1)))
  else
  begin
    $error("SCK level did not last DIVIDER+1 cycles");
    err_cnt++;
  end

  sck_idle_low: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    !cs_on |-> !spi_sck_i)
  else
  begin
    $error("SCK high with all chip selects released");
    err_cnt++;
  end

  cs_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    spi_sck_i |-> $stable(spi_cs_n_i))
  else
  begin
    $error("chip selects changed during an SCK high phase");
    err_cnt++;
  end

  // Driver follows direction for the whole transfer
  oe_follows_dir: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    cs_on |-> (spi_sdio_oe_i == dir_i))
  else
  begin
    $error("data pin enable does not match the transfer direction");
    err_cnt++;
  end

  oe_off_in_read: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    !dir_i |-> !spi_sdio_oe_i)
  else
  begin
    $error("data pin driven in read direction");
    err_cnt++;
  end

endmodule

// Config taken straight from the interface inside the top level
bind spi3w_top spi3w_chk u_chk (
  .clk_sys       (clk_sys),
  .rst_n_i       (rst_n_i),
  .bus_req_i     (bus_req_i),
  .bus_ack_i     (bus_ack_o),
  .spi_sck_i     (spi_sck_o),
  .spi_cs_n_i    (spi_cs_n_o),
  .spi_sdio_oe_i (spi_sdio_oe_o),
  .dir_i         (spi_if.dir),
  .div_i         (spi_if.div)
);

/* tb/spi3w_tb.sv */
`timescale 1ns/1ps
`include "spi3w_macros.svh"

module spi3w_tb;

  // Longest run is a few hundred cycles, wide margin
  localparam int TIMEOUT_CYC = 20000;

  logic                 clk_sys;
  logic                 rst_n_i;
  logic                 bus_req_i;
  logic                 bus_we_i;
  spi3w_pkg::reg_addr_t bus_addr_i;
  spi3w_pkg::spi_word_t bus_wdata_i;
  logic                 bus_ack_o;
  spi3w_pkg::spi_word_t bus_rdata_o;
  logic                 spi_sck_o;
  spi3w_pkg::spi_ss_t   spi_cs_n_o;
  logic                 spi_sdio_o;
  logic                 spi_sdio_oe_o;
  logic                 spi_sdio_i;

  // Peripheral model
  spi3w_pkg::spi_word_t cap_word;
  int                   cap_cnt;
  spi3w_pkg::spi_word_t rx_word;
  int                   rx_idx;
  int                   cycle_cnt = 0;

  spi3w_top u_spi3w_top (
    .clk_sys       (clk_sys),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_ack_o     (bus_ack_o),
    .bus_rdata_o   (bus_rdata_o),
    .spi_sck_o     (spi_sck_o),
    .spi_cs_n_o    (spi_cs_n_o),
    .spi_sdio_o    (spi_sdio_o),
    .spi_sdio_oe_o (spi_sdio_oe_o),
    .spi_sdio_i    (spi_sdio_i)
  );

  always #50 clk_sys = ~clk_sys;

  // --------------------------------------------------
  // Failure exit and value compare
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("mismatch at %0d ns: %s expected %h observed %h", $time, what, exp, got);
      abort_run("stopping at the first error");
    end
  endtask

  // Cycle limit, plus a watch on the bound protocol checker
  always @(posedge clk_sys)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
      abort_run("timeout, no completion");
    if (u_spi3w_top.u_chk.err_cnt != 0)
      abort_run("a protocol assertion failed");
  end

  // --------------------------------------------------
  // Register bus, one cycle per access
  // --------------------------------------------------
  task automatic bus_write(input spi3w_pkg::reg_addr_t addr, input spi3w_pkg::spi_word_t data);
    @(posedge clk_sys);
    #1;
    bus_req_i   = 1'b1;
    bus_we_i    = 1'b1;
    bus_addr_i  = addr;
    bus_wdata_i = data;
    @(posedge clk_sys);
    #1;
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    check_eq("write ack", {31'd0, bus_ack_o}, 32'd1);
  endtask

  task automatic bus_read(input spi3w_pkg::reg_addr_t addr, output spi3w_pkg::spi_word_t data);
    @(posedge clk_sys);
    #1;
    bus_req_i  = 1'b1;
    bus_we_i   = 1'b0;
    bus_addr_i = addr;
    @(posedge clk_sys);
    #1;
    bus_req_i = 1'b0;
    check_eq("read ack", {31'd0, bus_ack_o}, 32'd1);
    data = bus_rdata_o;
  endtask

  // Poll CTRL until the busy bit drops
  task automatic wait_idle();
    spi3w_pkg::spi_word_t ctrl;
    ctrl = '1;
    while (ctrl[`SPI3W_CTRL_GO_BIT])
      bus_read(`SPI3W_ADDR_CTRL, ctrl);
  endtask

  // --------------------------------------------------
  // One transfer and its expected result
  // --------------------------------------------------
  task automatic run_xfer(input logic wr_dir, input int len,
                          input spi3w_pkg::spi_word_t tx, input logic go_again);
    spi3w_pkg::spi_word_t mask;
    spi3w_pkg::spi_word_t ctrl;
    spi3w_pkg::spi_word_t got;
    mask = (len == 32) ? 32'hffff_ffff : ((32'd1 << len) - 32'd1);
    ctrl = '0;
    ctrl[`SPI3W_CTRL_LEN_LSB +: `SPI3W_LEN_W] = len[5:0];
    ctrl[`SPI3W_CTRL_DIR_BIT] = wr_dir;
    ctrl[`SPI3W_CTRL_GO_BIT]  = 1'b1;
    bus_write(`SPI3W_ADDR_DATA, tx);
    // First read bit ready before CS falls
    rx_word    = $urandom();
    rx_idx     = len - 1;
    spi_sdio_i = rx_word[len-1];
    cap_word   = '0;
    cap_cnt    = 0;
    bus_write(`SPI3W_ADDR_CTRL, ctrl);
    if (go_again)
    begin
      repeat (20) @(posedge clk_sys);
      // Longer length mid transfer, must be dropped
      ctrl[`SPI3W_CTRL_LEN_LSB +: `SPI3W_LEN_W] = 6'd20;
      bus_write(`SPI3W_ADDR_CTRL, ctrl);
    end
    wait_idle();
    check_eq("bit count", cap_cnt, len);
    if (wr_dir)
      check_eq("captured word", cap_word, tx & mask);
    else
    begin
      bus_read(`SPI3W_ADDR_DATA, got);
      check_eq("DATA after read", got, (tx << len) | (rx_word & mask));
    end
  endtask

  // Peripheral samples on SCK rise, CS0 only
  always @(posedge spi_sck_o)
  begin
    if (!spi_cs_n_o[0])
    begin
      cap_word = {cap_word[30:0], spi_sdio_o};
      cap_cnt  = cap_cnt + 1;
    end
    check_eq("chip selects at SCK rise", {28'd0, spi_cs_n_o}, 32'he);
  end

  // Next read bit after each SCK fall
  always @(negedge spi_sck_o)
  begin
    #1;
    if (rx_idx > 0)
    begin
      rx_idx     = rx_idx - 1;
      spi_sdio_i = rx_word[rx_idx];
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    spi3w_pkg::spi_word_t rd;
    void'($urandom(19510));
    clk_sys     = 1'b0;
    rst_n_i     = 1'b0;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    spi_sdio_i  = 1'b0;
    cap_word    = '0;
    cap_cnt     = 0;
    rx_word     = '0;
    rx_idx      = 0;
    repeat (3) @(posedge clk_sys);
    #1;
    rst_n_i = 1'b1;

    // Pins and registers out of reset
    check_eq("cs_n after reset", {28'd0, spi_cs_n_o}, 32'hf);
    check_eq("sck after reset", {31'd0, spi_sck_o}, 32'd0);
    check_eq("oe after reset", {31'd0, spi_sdio_oe_o}, 32'd0);
    check_eq("ack after reset", {31'd0, bus_ack_o}, 32'd0);
    bus_read(`SPI3W_ADDR_DATA, rd);
    check_eq("DATA reset", rd, 32'd0);
    bus_read(`SPI3W_ADDR_CTRL, rd);
    check_eq("CTRL reset", rd, 32'd0);
    bus_read(`SPI3W_ADDR_SS, rd);
    check_eq("SS reset", rd, 32'd0);
    bus_read(`SPI3W_ADDR_DIV, rd);
    check_eq("DIVIDER reset", rd, 32'd3);

    // Plain readback
    bus_write(`SPI3W_ADDR_DIV, 32'h5a);
    bus_read(`SPI3W_ADDR_DIV, rd);
    check_eq("DIVIDER readback", rd, 32'h5a);
    bus_write(`SPI3W_ADDR_SS, 32'ha);
    bus_read(`SPI3W_ADDR_SS, rd);
    check_eq("SS readback", rd, 32'ha);
    bus_write(`SPI3W_ADDR_DATA, 32'h1234_5678);
    bus_read(`SPI3W_ADDR_DATA, rd);
    check_eq("DATA readback", rd, 32'h1234_5678);

    // Full word out on CS0
    bus_write(`SPI3W_ADDR_DIV, 32'd3);
    bus_write(`SPI3W_ADDR_SS, 32'd1);
    run_xfer(1'b1, 32, 32'hdead_beef, 1'b0);

    // Reads, full and partial word
    run_xfer(1'b0, 32, 32'h0f0f_1234, 1'b0);
    run_xfer(1'b0, 12, $urandom(), 1'b0);

    // Fastest SCK, then slow SCK with a go while busy
    bus_write(`SPI3W_ADDR_DIV, 32'd0);
    run_xfer(1'b1, 8, 32'h0000_00a5, 1'b0);
    bus_write(`SPI3W_ADDR_DIV, 32'd5);
    run_xfer(1'b0, 12, $urandom(), 1'b1);

    repeat (4) @(posedge clk_sys);
    if (u_spi3w_top.u_chk.err_cnt == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
      abort_run("a protocol assertion failed");
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/spi3w_pkg.sv
verilog/spi3w_if.sv
verilog/spi3w_reg_bank.sv
verilog/spi3w_seq_fsm.sv
verilog/spi3w_bit_timer.sv
verilog/spi3w_shift_reg.sv
verilog/spi3w_top.sv
tb/spi3w_chk.sv
tb/spi3w_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := spi3w_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED
# Keep running after a checker error so the testbench can report it
RUN_ARGS := +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
